// File: tb.f
hdl/uart_dbg_pkg.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/dbg_cmd_fsm.sv
hdl/dbg_mem.sv
hdl/uart_dbg_top.sv
testbench/tb_uart_dbg.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_uart_dbg -o tb_uart_dbg
./obj_dir/tb_uart_dbg > sim.log 2>&1
cat sim.log

if grep -qx "Simulation completed successfully" sim.log; then
  exit 0
fi
exit 1

// File: testbench/tb_uart_dbg.sv
//////////////////////////////////////////////////
// Testbench for the UART debug server
// Serial host driver and reply monitor, table of
// commands, reference memory model and watchdog
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module tb_uart_dbg
  import uart_dbg_pkg::*;
();

  typedef enum logic [1:0] {
    K_CHAL,
    K_WRITE,
    K_READ,
    K_JUNK
  } op_kind_e;

  // One command: kind, start address (junk byte value for K_JUNK), length
  typedef struct packed {
    op_kind_e   kind;
    logic [7:0] addr;
    logic [8:0] len;
  } op_row_t;

  localparam int NUM_OPS = 13;
  localparam int BIT_NS  = CLKS_PER_BIT * 10;

  logic clk = 1'b0;
  logic arst_n_i;
  logic uart_rx_i;
  logic uart_tx_o;

  logic [7:0]  ref_mem [MEM_DEPTH];
  logic [7:0]  rx_q [$];
  logic        mon_busy  = 1'b0;
  logic [31:0] lcg_state = 32'hf56c;
  int          err_cnt   = 0;
  int          chk_cnt   = 0;

  op_row_t ops [NUM_OPS] = '{
    '{K_CHAL,  8'h00, 9'd0},
    '{K_WRITE, 8'h10, 9'd6},
    '{K_READ,  8'h10, 9'd6},
    '{K_READ,  8'h80, 9'd4},
    '{K_WRITE, 8'hfc, 9'd7},
    '{K_READ,  8'h00, 9'd4},
    '{K_READ,  8'hf8, 9'd8},
    '{K_JUNK,  8'h55, 9'd0},
    '{K_CHAL,  8'h00, 9'd0},
    '{K_WRITE, 8'h20, 9'd0},
    '{K_READ,  8'h20, 9'd0},
    '{K_WRITE, 8'h00, 9'd256},
    '{K_READ,  8'h00, 9'd256}
  };

  uart_dbg_top dut (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .uart_rx_i(uart_rx_i),
    .uart_tx_o(uart_tx_o)
  );

  always #5 clk = ~clk;

  function automatic logic [7:0] next_rand_byte();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[23:16];
  endfunction

  //////////////////////////////////////////////////
  // Host side serial driver
  //////////////////////////////////////////////////

  task automatic send_byte(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      uart_rx_i <= frame[i];
      repeat (CLKS_PER_BIT - 1) @(posedge clk);
    end
  endtask

  // Address LSB first; upper address bytes are don't care for 256 bytes
  task automatic send_header(input logic [7:0] addr, input logic [8:0] len);
    for (int i = 0; i < HDR_BYTES; i++) begin
      send_byte((i == 0) ? addr : 8'h3c);
    end
    for (int i = 0; i < HDR_BYTES; i++) begin
      send_byte((i == 0) ? len[7:0] : (i == 1) ? {7'b0, len[8]} : 8'h00);
    end
  endtask

  task automatic expect_reply(input logic [7:0] exp, input string what);
    logic [7:0] got;
    while (rx_q.size() == 0) begin
      @(posedge clk);
    end
    got = rx_q.pop_front();
    chk_cnt++;
    assert (got === exp) else begin
      err_cnt++;
      $display("** Error at %0t ns: uart_tx_o (%s) expected %02h, got %02h",
               $time, what, exp, got);
    end
  endtask

  // Line must stay high with no frame for the given number of bit times
  task automatic check_quiet(input int bits);
    logic stayed_high;
    stayed_high = 1'b1;
    repeat (bits * CLKS_PER_BIT) begin
      @(posedge clk);
      if (!uart_tx_o) begin
        stayed_high = 1'b0;
      end
    end
    chk_cnt++;
    assert (stayed_high && !mon_busy && rx_q.size() == 0) else begin
      err_cnt++;
      $display("Unexpected activity on uart_tx_o while no reply was due, at %0t ns", $time);
      rx_q.delete();
    end
  endtask

  task automatic run_row(input op_row_t row);
    logic [7:0] a;
    logic [7:0] d;
    case (row.kind)
      K_CHAL: begin
        send_byte(OP_ACK);
        expect_reply(OP_ACK, "challenge reply");
        check_quiet(12);
      end
      K_JUNK: begin
        send_byte(row.addr);
        check_quiet(12);
      end
      default: begin
        send_byte((row.kind == K_WRITE) ? OP_WRITE : OP_READ);
        send_header(row.addr, row.len);
        expect_reply(OP_ACK, "header ACK");
        for (int i = 0; i < int'(row.len); i++) begin
          a = row.addr + 8'(i);
          if (row.kind == K_WRITE) begin
            d = next_rand_byte();
            send_byte(d);
            ref_mem[a] = d;
          end else begin
            expect_reply(ref_mem[a], "read data");
          end
        end
        expect_reply(OP_EOT, "EOT");
        check_quiet(12);
      end
    endcase
  endtask

  //////////////////////////////////////////////////
  // Reply monitor
  //////////////////////////////////////////////////

  initial begin : tx_monitor
    logic [7:0] data;
    logic       frame_ok;
    @(posedge arst_n_i);
    forever begin
      @(negedge uart_tx_o);
      mon_busy = 1'b1;
      repeat (CLKS_PER_BIT / 2) @(posedge clk);
      frame_ok = !uart_tx_o;
      for (int i = 0; i < BYTE_W; i++) begin
        repeat (CLKS_PER_BIT) @(posedge clk);
        data[i] = uart_tx_o;
      end
      repeat (CLKS_PER_BIT) @(posedge clk);
      frame_ok = frame_ok && uart_tx_o;
      chk_cnt++;
      assert (frame_ok) else begin
        err_cnt++;
        $display("Bad start or stop bit in a frame on uart_tx_o at %0t ns", $time);
      end
      rx_q.push_back(data);
      mon_busy = 1'b0;
    end
  end

  // Budget of header, data and 3 extra bytes per row, doubled
  initial begin : watchdog
    longint limit_ns;
    @(posedge arst_n_i);
    limit_ns = 0;
    for (int r = 0; r < NUM_OPS; r++) begin
      limit_ns = limit_ns + (2 * HDR_BYTES + longint'(ops[r].len) + 3) * 10 * BIT_NS;
    end
    limit_ns = limit_ns * 2;
    #(limit_ns);
    $display("Timeout after %0d ns: the DUT did not send an expected reply", limit_ns);
    $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt + 1);
    $display("Simulation failed");
    $finish;
  end

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    uart_rx_i = 1'b1;
    arst_n_i  = 1'b0;
    for (int i = 0; i < MEM_DEPTH; i++) begin
      ref_mem[i] = '0;
    end
    repeat (5) @(posedge clk);
    arst_n_i <= 1'b1;
    // No frame may appear before the first command
    check_quiet(20);
    for (int r = 0; r < NUM_OPS; r++) begin
      run_row(ops[r]);
    end
    $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: hdl/uart_dbg_top.sv
//////////////////////////////////////////////////
// UART debug server top level
// Receiver, protocol FSM, memory, transmitter
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module uart_dbg_top
  import uart_dbg_pkg::*;
(
  input  logic clk,
  input  logic arst_n_i,
  input  logic uart_rx_i,
  output logic uart_tx_o
);

  logic              rx_valid;
  logic [BYTE_W-1:0] rx_byte;
  logic              mem_valid;
  mem_req_t          mem_req;
  logic [BYTE_W-1:0] mem_rdata;
  logic              tx_start;
  logic [BYTE_W-1:0] tx_byte;
  logic              tx_busy;

  uart_rx u_rx (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .rx_i        (uart_rx_i),
    .byte_valid_o(rx_valid),
    .byte_o      (rx_byte)
  );

  dbg_cmd_fsm u_fsm (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .rx_valid_i (rx_valid),
    .rx_byte_i  (rx_byte),
    .mem_valid_o(mem_valid),
    .mem_req_o  (mem_req),
    .mem_rdata_i(mem_rdata),
    .tx_start_o (tx_start),
    .tx_byte_o  (tx_byte),
    .tx_busy_i  (tx_busy)
  );

  dbg_mem u_mem (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .req_valid_i(mem_valid),
    .req_i      (mem_req),
    .rdata_o    (mem_rdata)
  );

  uart_tx u_tx (
    .clk     (clk),
    .arst_n_i(arst_n_i),
    .start_i (tx_start),
    .byte_i  (tx_byte),
    .busy_o  (tx_busy),
    .tx_o    (uart_tx_o)
  );

endmodule

`default_nettype wire

// File: hdl/dbg_mem.sv
//////////////////////////////////////////////////
// Debug memory
// 256 bytes, one write port, registered read
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module dbg_mem
  import uart_dbg_pkg::*;
(
  input  logic              clk,
  input  logic              arst_n_i,
  input  logic              req_valid_i,
  input  mem_req_t          req_i,
  output logic [BYTE_W-1:0] rdata_o
);

  logic [BYTE_W-1:0] mem_q [MEM_DEPTH];

  // Contents start out as zeros
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < MEM_DEPTH; i++) begin
        mem_q[i] <= '0;
      end
    end else if (req_valid_i && req_i.we) begin
      mem_q[req_i.addr] <= req_i.wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid_i && !req_i.we) begin
      rdata_o <= mem_q[req_i.addr];
    end
  end

endmodule

`default_nettype wire

// File: hdl/dbg_cmd_fsm.sv
//////////////////////////////////////////////////
// Debug protocol FSM
// Parses ACK, READ and WRITE, collects the
// address and length header and sequences the
// ACK, data and EOT replies
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module dbg_cmd_fsm
  import uart_dbg_pkg::*;
(
  input  logic              clk,
  input  logic              arst_n_i,
  input  logic              rx_valid_i,
  input  logic [BYTE_W-1:0] rx_byte_i,
  output logic              mem_valid_o,
  output mem_req_t          mem_req_o,
  input  logic [BYTE_W-1:0] mem_rdata_i,
  output logic              tx_start_o,
  output logic [BYTE_W-1:0] tx_byte_o,
  input  logic              tx_busy_i
);

  dbg_state_e           state_q;
  dbg_op_e              cmd_q;
  logic [HDR_CNT_W-1:0] hdr_cnt_q;
  logic [MEM_AW-1:0]    addr_q;
  logic [LEN_W-1:0]     len_q;
  logic                 rd_wait_q;
  logic                 tx_start_q;
  logic [BYTE_W-1:0]    tx_byte_q;
  logic                 tx_ready;
  logic                 hdr_last;
  logic                 rd_issue;

  // Transmitter free and no start pulse still in flight
  assign tx_ready = !tx_busy_i && !tx_start_q;
  assign hdr_last = (hdr_cnt_q == HDR_CNT_W'(HDR_BYTES - 1));
  assign rd_issue = (state_q == ST_READ_DATA) && !rd_wait_q && tx_ready;

  assign mem_valid_o     = rd_issue || ((state_q == ST_WRITE_DATA) && rx_valid_i);
  assign mem_req_o.we    = (state_q == ST_WRITE_DATA);
  assign mem_req_o.addr  = addr_q;
  assign mem_req_o.wdata = rx_byte_i;

  assign tx_start_o = tx_start_q;
  assign tx_byte_o  = tx_byte_q;

  //////////////////////////////////////////////////
  // Protocol sequencing
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= ST_IDLE;
      cmd_q      <= OP_ACK;
      hdr_cnt_q  <= '0;
      addr_q     <= '0;
      len_q      <= '0;
      rd_wait_q  <= 1'b0;
      tx_start_q <= 1'b0;
      tx_byte_q  <= '0;
    end else begin
      tx_start_q <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (rx_valid_i) begin
            hdr_cnt_q <= '0;
            case (rx_byte_i)
              OP_ACK: begin
                cmd_q   <= OP_ACK;
                state_q <= ST_SEND_ACK;
              end
              OP_READ, OP_WRITE: begin
                cmd_q   <= dbg_op_e'(rx_byte_i);
                state_q <= ST_ADDR;
              end
              default: state_q <= ST_IDLE;
            endcase
          end
        end
        ST_ADDR: begin
          if (rx_valid_i) begin
            // Only the low byte addresses the 256-byte memory
            if (hdr_cnt_q == '0) begin
              addr_q <= rx_byte_i;
            end
            hdr_cnt_q <= hdr_cnt_q + 1'b1;
            if (hdr_last) begin
              state_q <= ST_LEN;
            end
          end
        end
        ST_LEN: begin
          if (rx_valid_i) begin
            hdr_cnt_q <= hdr_cnt_q + 1'b1;
            if (hdr_cnt_q == '0) begin
              len_q <= {1'b0, rx_byte_i};
            end else if (hdr_cnt_q == HDR_CNT_W'(1)) begin
              // Anything above 256 saturates
              if (|rx_byte_i[BYTE_W-1:1] || (rx_byte_i[0] && |len_q[BYTE_W-1:0])) begin
                len_q <= LEN_W'(MEM_DEPTH);
              end else begin
                len_q[BYTE_W] <= rx_byte_i[0];
              end
            end else if (|rx_byte_i) begin
              len_q <= LEN_W'(MEM_DEPTH);
            end
            if (hdr_last) begin
              state_q <= ST_SEND_ACK;
            end
          end
        end
        ST_SEND_ACK: begin
          if (tx_ready) begin
            tx_start_q <= 1'b1;
            tx_byte_q  <= OP_ACK;
            rd_wait_q  <= 1'b0;
            if (cmd_q == OP_ACK) begin
              state_q <= ST_IDLE;
            end else if (len_q == '0) begin
              state_q <= ST_SEND_EOT;
            end else if (cmd_q == OP_READ) begin
              state_q <= ST_READ_DATA;
            end else begin
              state_q <= ST_WRITE_DATA;
            end
          end
        end
        ST_READ_DATA: begin
          // Fetch, then send once the memory data is valid
          if (rd_wait_q) begin
            rd_wait_q  <= 1'b0;
            tx_start_q <= 1'b1;
            tx_byte_q  <= mem_rdata_i;
            addr_q     <= addr_q + 1'b1;
            len_q      <= len_q - 1'b1;
            if (len_q == LEN_W'(1)) begin
              state_q <= ST_SEND_EOT;
            end
          end else if (rd_issue) begin
            rd_wait_q <= 1'b1;
          end
        end
        ST_WRITE_DATA: begin
          if (rx_valid_i) begin
            addr_q <= addr_q + 1'b1;
            len_q  <= len_q - 1'b1;
            if (len_q == LEN_W'(1)) begin
              state_q <= ST_SEND_EOT;
            end
          end
        end
        ST_SEND_EOT: begin
          if (tx_ready) begin
            tx_start_q <= 1'b1;
            tx_byte_q  <= OP_EOT;
            state_q    <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hdl/uart_tx.sv
//////////////////////////////////////////////////
// UART transmitter
// One 8N1 frame per start pulse, busy for the
// full ten bit times
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module uart_tx
  import uart_dbg_pkg::*;
(
  input  logic              clk,
  input  logic              arst_n_i,
  input  logic              start_i,
  input  logic [BYTE_W-1:0] byte_i,
  output logic              busy_o,
  output logic              tx_o
);

  logic [BYTE_W+1:0]      frame_q;
  logic                   busy_q;
  logic [CYC_W-1:0]       cyc_q;
  logic [FRAME_IDX_W-1:0] bit_q;

  // Frame register idles at all ones so the line rests high
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      frame_q <= '1;
      busy_q  <= 1'b0;
      cyc_q   <= '0;
      bit_q   <= '0;
    end else if (!busy_q) begin
      if (start_i) begin
        frame_q <= {1'b1, byte_i, 1'b0};
        busy_q  <= 1'b1;
        cyc_q   <= '0;
        bit_q   <= '0;
      end
    end else if (cyc_q == CYC_W'(CLKS_PER_BIT - 1)) begin
      cyc_q   <= '0;
      frame_q <= {1'b1, frame_q[BYTE_W+1:1]};
      if (bit_q == FRAME_IDX_W'(BYTE_W + 1)) begin
        busy_q <= 1'b0;
      end else begin
        bit_q <= bit_q + 1'b1;
      end
    end else begin
      cyc_q <= cyc_q + 1'b1;
    end
  end

  assign busy_o = busy_q;
  assign tx_o   = frame_q[0];

endmodule

`default_nettype wire

// File: hdl/uart_rx.sv
//////////////////////////////////////////////////
// UART receiver
// 8N1 frames, mid-bit sampling, one strobe per
// frame with a valid stop bit
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module uart_rx
  import uart_dbg_pkg::*;
(
  input  logic              clk,
  input  logic              arst_n_i,
  input  logic              rx_i,
  output logic              byte_valid_o,
  output logic [BYTE_W-1:0] byte_o
);

  logic [2:0]             sync_q;
  logic                   line;
  logic                   start_edge;
  logic                   busy_q;
  logic [CYC_W-1:0]       cyc_q;
  logic [FRAME_IDX_W-1:0] bit_q;
  logic                   sample;
  logic                   valid_q;
  logic [BYTE_W-1:0]      shift_q;

  // Two sync stages plus one history stage for the edge
  assign line       = sync_q[1];
  assign start_edge = !busy_q && sync_q[2] && !sync_q[1];

  // Start bit is checked half a bit in, the rest one full bit apart
  assign sample = busy_q && (cyc_q == ((bit_q == '0) ? CYC_W'(CLKS_PER_BIT / 2 - 1)
                                                     : CYC_W'(CLKS_PER_BIT - 1)));

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q  <= '1;
      busy_q  <= 1'b0;
      cyc_q   <= '0;
      bit_q   <= '0;
      valid_q <= 1'b0;
    end else begin
      sync_q  <= {sync_q[1:0], rx_i};
      valid_q <= 1'b0;
      if (!busy_q) begin
        if (start_edge) begin
          busy_q <= 1'b1;
          cyc_q  <= '0;
          bit_q  <= '0;
        end
      end else if (sample) begin
        cyc_q <= '0;
        bit_q <= bit_q + 1'b1;
        if (bit_q == '0 && line) begin
          // Glitch, not a real start bit
          busy_q <= 1'b0;
        end else if (bit_q == FRAME_IDX_W'(BYTE_W + 1)) begin
          busy_q  <= 1'b0;
          valid_q <= line;
        end
      end else begin
        cyc_q <= cyc_q + 1'b1;
      end
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge clk) begin
    if (sample && bit_q != '0 && bit_q <= FRAME_IDX_W'(BYTE_W)) begin
      shift_q <= {line, shift_q[BYTE_W-1:1]};
    end
  end

  assign byte_valid_o = valid_q;
  assign byte_o       = shift_q;

endmodule

`default_nettype wire

// File: hdl/uart_dbg_pkg.sv
//////////////////////////////////////////////////
// Shared definitions for the UART debug server
// Line timing, byte and memory sizes, protocol
// opcodes, FSM states and the memory request
//////////////////////////////////////////////////

`default_nettype none

package uart_dbg_pkg;

  // Serial line and memory geometry
  localparam int CLKS_PER_BIT = 16;
  localparam int BYTE_W       = 8;
  localparam int MEM_AW       = 8;
  localparam int MEM_DEPTH    = 256;
  localparam int HDR_BYTES    = 8;

  // Derived counter widths
  localparam int CYC_W        = $clog2(CLKS_PER_BIT);
  localparam int FRAME_IDX_W  = $clog2(BYTE_W + 2);
  localparam int HDR_CNT_W    = $clog2(HDR_BYTES);
  localparam int LEN_W        = MEM_AW + 1;

  // Protocol bytes
  typedef enum logic [7:0] {
    OP_EOT   = 8'h04,
    OP_ACK   = 8'h06,
    OP_READ  = 8'h11,
    OP_WRITE = 8'h12
  } dbg_op_e;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_ADDR,
    ST_LEN,
    ST_SEND_ACK,
    ST_READ_DATA,
    ST_WRITE_DATA,
    ST_SEND_EOT
  } dbg_state_e;

  // One byte access to the debug memory
  typedef struct packed {
    logic              we;
    logic [MEM_AW-1:0] addr;
    logic [BYTE_W-1:0] wdata;
  } mem_req_t;

endpackage

`default_nettype wire
